// File: all.f
src/axi_pkg.sv
src/pad_pkg.sv
src/sync_fifo.sv
src/pad_rd_engine.sv
src/pad_wr_engine.sv
src/pad_ctrl.sv
src/mirror_pad_dma.sv
tb/axi_mem_model.sv
tb/mirror_pad_dma_assert.sv
tb/tb_mirror_pad_dma.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mirror padding DMA testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mirror_pad_dma -Mdir obj_dir -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_mirror_pad_dma
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

echo "Simulation completed"
exit 0

// File: src/axi_pkg.sv
/*
 * Field types and fixed encodings for the single-beat AXI3 master port.
 * Imported by the engines and the top level wherever bus fields are formed.
 */
package axi_pkg;

    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] data_t;  // One bus word
    typedef logic [1:0]  resp_t;  // RRESP / BRESP code

    // Response codes
    localparam resp_t RESP_OKAY = 2'b00;

    // Fixed burst shape, one 4-byte beat per transaction
    localparam logic [2:0] SIZE_WORD  = 3'b010;
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [3:0] LEN_SINGLE = 4'd0;

    // Address step from one word to the next
    localparam int unsigned BYTES_PER_WORD = 32'd4;

endpackage

// File: src/mirror_pad_dma.sv
/*
 * Mirror padding DMA top level. Copies a W x W word matrix to a (W+2) x (W+2)
 * edge-reflected image through an AXI3 single-beat master port.
 */
`timescale 1ns/100ps

module mirror_pad_dma #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    // Configuration
    input  axi_pkg::addr_t  src_addr_i,
    input  axi_pkg::addr_t  dst_addr_i,
    input  pad_pkg::width_t mat_width_i,
    input  logic            start_i,
    output logic            done_o,
    output logic            err_o,
    // AR channel
    output axi_pkg::addr_t  araddr_o,
    output logic [3:0]      arlen_o,
    output logic [2:0]      arsize_o,
    output logic [1:0]      arburst_o,
    output logic [3:0]      arid_o,
    output logic            arvalid_o,
    input  logic            arready_i,
    // R channel
    input  axi_pkg::data_t  rdata_i,
    input  axi_pkg::resp_t  rresp_i,
    input  logic            rlast_i,
    input  logic            rvalid_i,
    output logic            rready_o,
    // AW channel
    output axi_pkg::addr_t  awaddr_o,
    output logic [3:0]      awlen_o,
    output logic [2:0]      awsize_o,
    output logic [1:0]      awburst_o,
    output logic [3:0]      awid_o,
    output logic            awvalid_o,
    input  logic            awready_i,
    // W channel
    output axi_pkg::data_t  wdata_o,
    output logic [3:0]      wstrb_o,
    output logic            wlast_o,
    output logic [3:0]      wid_o,
    output logic            wvalid_o,
    input  logic            wready_i,
    // B channel
    input  axi_pkg::resp_t  bresp_i,
    input  logic            bvalid_i,
    output logic            bready_o
);

    import axi_pkg::*;
    import pad_pkg::*;

    logic   go;
    addr_t  src_base, dst_base;
    width_t width;
    logic   rd_done, wr_done, rd_err, wr_err;
    logic   push, pop, fifo_empty;
    data_t  push_data, pop_data;
    resp_t  rd_resp;

    // Every transaction is one full-word beat with ID 0
    assign arlen_o   = LEN_SINGLE;
    assign arsize_o  = SIZE_WORD;
    assign arburst_o = BURST_INCR;
    assign arid_o    = 4'd0;
    assign awlen_o   = LEN_SINGLE;
    assign awsize_o  = SIZE_WORD;
    assign awburst_o = BURST_INCR;
    assign awid_o    = 4'd0;
    assign wid_o     = 4'd0;
    assign wstrb_o   = 4'hF;
    assign wlast_o   = 1'b1;

    assign rd_resp = rresp_i | {~rlast_i, 1'b0};  // Missing rlast reads as a slave error

    pad_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .rd_done_i   (rd_done),
        .wr_done_i   (wr_done),
        .rd_err_i    (rd_err),
        .wr_err_i    (wr_err),
        .go_o        (go),
        .src_base_o  (src_base),
        .dst_base_o  (dst_base),
        .width_o     (width),
        .done_o      (done_o),
        .err_o       (err_o)
    );

    pad_rd_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_rd (
        .clk         (clk),
        .rst_n       (rst_n),
        .go_i        (go),
        .src_base_i  (src_base),
        .width_i     (width),
        .araddr_o    (araddr_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rdata_i     (rdata_i),
        .rresp_i     (rd_resp),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .push_o      (push),
        .push_data_o (push_data),
        .pop_i       (pop),
        .rd_done_o   (rd_done),
        .rd_err_o    (rd_err)
    );

    sync_fifo #(.payload_t(data_t), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .full_o      (),            // Read credits already bound the fill level
        .empty_o     (fifo_empty)
    );

    pad_wr_engine u_wr (
        .clk         (clk),
        .rst_n       (rst_n),
        .go_i        (go),
        .dst_base_i  (dst_base),
        .width_i     (width),
        .empty_i     (fifo_empty),
        .pop_data_i  (pop_data),
        .pop_o       (pop),
        .awaddr_o    (awaddr_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bresp_i     (bresp_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o),
        .wr_done_o   (wr_done),
        .wr_err_o    (wr_err)
    );

endmodule

// File: src/pad_ctrl.sv
/*
 * Start/done controller. Latches the job configuration on start, kicks both
 * engines with a go pulse and reports done once both engines have finished.
 */
`timescale 1ns/100ps

module pad_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  axi_pkg::addr_t  src_addr_i,
    input  axi_pkg::addr_t  dst_addr_i,
    input  pad_pkg::width_t mat_width_i,
    input  logic            rd_done_i,
    input  logic            wr_done_i,
    input  logic            rd_err_i,
    input  logic            wr_err_i,
    output logic            go_o,
    output axi_pkg::addr_t  src_base_o,
    output axi_pkg::addr_t  dst_base_o,
    output pad_pkg::width_t width_o,
    output logic            done_o,
    output logic            err_o
);

    import pad_pkg::*;

    typedef enum logic {S_IDLE, S_BUSY} state_t;

    state_t state_q;
    logic   rd_seen_q, wr_seen_q;
    logic   accept;
    logic   finish;

    assign done_o = (state_q == S_IDLE);
    assign accept = done_o && start_i;
    // Both pulses may land in the same cycle
    assign finish = (state_q == S_BUSY) && (rd_seen_q || rd_done_i) && (wr_seen_q || wr_done_i);

    always_ff @(posedge clk) begin
        if (accept) begin
            src_base_o <= src_addr_i;
            dst_base_o <= dst_addr_i;
            width_o    <= (mat_width_i < MIN_WIDTH) ? width_t'(MIN_WIDTH) : mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            go_o      <= 1'b0;
            rd_seen_q <= 1'b0;
            wr_seen_q <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            go_o <= accept;
            if (accept) begin
                state_q   <= S_BUSY;
                rd_seen_q <= 1'b0;
                wr_seen_q <= 1'b0;
                err_o     <= 1'b0;
            end else if (finish) begin
                state_q <= S_IDLE;
                err_o   <= rd_err_i || wr_err_i;  // Sticky until the next start
            end else begin
                rd_seen_q <= rd_seen_q || rd_done_i;
                wr_seen_q <= wr_seen_q || wr_done_i;
            end
        end
    end

endmodule

// File: src/pad_pkg.sv
/*
 * Matrix geometry for the mirror padding engine.
 * Sizes cover a W x W source with W up to 63, giving a 65 x 65 output.
 */
package pad_pkg;

    // Source width W
    typedef logic [5:0] width_t;

    // Output row or column, 0..W+1
    typedef logic [6:0] coord_t;

    // Output word count, up to 65*65
    typedef logic [12:0] count_t;

    // Mirroring without the edge needs two source rows
    localparam int unsigned MIN_WIDTH = 32'd2;

endpackage

// File: src/pad_rd_engine.sv
/*
 * Read side of the padding DMA. Walks the padded output in row-major order,
 * maps every coordinate back into the source and issues one AR per word.
 * Credits keep reads in flight plus FIFO contents within FIFO_DEPTH.
 */
`timescale 1ns/100ps

module pad_rd_engine #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go_i,
    input  axi_pkg::addr_t  src_base_i,
    input  pad_pkg::width_t width_i,
    output axi_pkg::addr_t  araddr_o,
    output logic            arvalid_o,
    input  logic            arready_i,
    input  axi_pkg::data_t  rdata_i,
    input  axi_pkg::resp_t  rresp_i,
    input  logic            rvalid_i,
    output logic            rready_o,
    output logic            push_o,
    output axi_pkg::data_t  push_data_o,
    input  logic            pop_i,
    output logic            rd_done_o,
    output logic            rd_err_o
);

    import axi_pkg::*;
    import pad_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH) + 1;

    logic          busy_q;
    logic          err_q;
    coord_t        row_q, col_q;
    count_t        iss_cnt_q;   // AR requests loaded so far
    count_t        r_cnt_q;     // R beats accepted so far
    logic [CW-1:0] credit_q;    // Issued reads not yet popped by the writer

    coord_t        row_c, col_c;
    count_t        iss_cnt_c;
    coord_t        last_idx;
    count_t        total;
    logic          issue;
    logic          r_hs;
    addr_t         offset;

    // Reflection without the edge: 0 -> 1, W+1 -> W-2, else r-1
    function automatic coord_t mirror_idx(coord_t idx, coord_t last);
        if (idx == '0) begin
            return coord_t'(1);
        end else if (idx == last) begin
            return last - coord_t'(3);
        end
        return idx - coord_t'(1);
    endfunction

    assign last_idx = coord_t'(width_i) + coord_t'(1);
    assign total    = (count_t'(width_i) + count_t'(2)) * (count_t'(width_i) + count_t'(2));

    // A go restarts the walk at the origin in the same cycle
    assign row_c     = go_i ? '0 : row_q;
    assign col_c     = go_i ? '0 : col_q;
    assign iss_cnt_c = go_i ? '0 : iss_cnt_q;

    assign offset = (addr_t'(mirror_idx(row_c, last_idx)) * addr_t'(width_i)
                   + addr_t'(mirror_idx(col_c, last_idx))) * BYTES_PER_WORD;

    assign issue = (go_i || busy_q) && (iss_cnt_c != total)
                && (credit_q != CW'(FIFO_DEPTH)) && (!arvalid_o || arready_i);

    assign rready_o    = busy_q;
    assign r_hs        = rvalid_i && rready_o;
    assign push_o      = r_hs;       // Credits guarantee a free slot
    assign push_data_o = rdata_i;
    assign rd_done_o   = r_hs && (r_cnt_q == total - count_t'(1));
    assign rd_err_o    = err_q || (r_hs && (rresp_i != RESP_OKAY));

    always_ff @(posedge clk) begin
        if (issue) begin
            araddr_o <= src_base_i + offset;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            err_q     <= 1'b0;
            arvalid_o <= 1'b0;
            row_q     <= '0;
            col_q     <= '0;
            iss_cnt_q <= '0;
            r_cnt_q   <= '0;
            credit_q  <= '0;
        end else begin
            credit_q <= credit_q + CW'(issue) - CW'(pop_i);

            if (issue) begin
                arvalid_o <= 1'b1;
                iss_cnt_q <= iss_cnt_c + count_t'(1);
                if (col_c == last_idx) begin  // End of an output row
                    col_q <= '0;
                    row_q <= row_c + coord_t'(1);
                end else begin
                    col_q <= col_c + coord_t'(1);
                    row_q <= row_c;
                end
            end else if (arready_i) begin
                arvalid_o <= 1'b0;
            end

            if (go_i) begin
                busy_q  <= 1'b1;
                err_q   <= 1'b0;
                r_cnt_q <= '0;
            end else if (r_hs) begin
                r_cnt_q <= r_cnt_q + count_t'(1);
                err_q   <= rd_err_o;
                if (rd_done_o) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

endmodule

// File: src/pad_wr_engine.sv
/*
 * Write side of the padding DMA. Drains the FIFO one word at a time into
 * consecutive destination addresses, one AW/W/B transaction outstanding.
 */
`timescale 1ns/100ps

module pad_wr_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go_i,
    input  axi_pkg::addr_t  dst_base_i,
    input  pad_pkg::width_t width_i,
    input  logic            empty_i,
    input  axi_pkg::data_t  pop_data_i,
    output logic            pop_o,
    output axi_pkg::addr_t  awaddr_o,
    output logic            awvalid_o,
    input  logic            awready_i,
    output axi_pkg::data_t  wdata_o,
    output logic            wvalid_o,
    input  logic            wready_i,
    input  axi_pkg::resp_t  bresp_i,
    input  logic            bvalid_i,
    output logic            bready_o,
    output logic            wr_done_o,
    output logic            wr_err_o
);

    import axi_pkg::*;
    import pad_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,   // Running, FIFO empty
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t state_q;
    count_t b_cnt_q;
    logic   err_q;
    count_t total;
    logic   b_hs;

    assign total = (count_t'(width_i) + count_t'(2)) * (count_t'(width_i) + count_t'(2));

    assign awvalid_o = (state_q == S_ADDR);
    assign wvalid_o  = (state_q == S_DATA);
    assign bready_o  = (state_q == S_RESP);
    assign wdata_o   = pop_data_i;            // FIFO head holds until popped
    assign pop_o     = wvalid_o && wready_i;

    assign b_hs      = bvalid_i && bready_o;
    assign wr_done_o = b_hs && (b_cnt_q == total - count_t'(1));
    assign wr_err_o  = err_q || (b_hs && (bresp_i != RESP_OKAY));

    // Destination pointer steps one word per completed write
    always_ff @(posedge clk) begin
        if (go_i) begin
            awaddr_o <= dst_base_i;
        end else if (b_hs) begin
            awaddr_o <= awaddr_o + BYTES_PER_WORD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            b_cnt_q <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (go_i) begin
                        state_q <= S_WAIT;
                        b_cnt_q <= '0;
                        err_q   <= 1'b0;
                    end
                end
                S_WAIT: begin
                    if (!empty_i) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (awready_i) begin
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (wready_i) begin
                        state_q <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_hs) begin
                        b_cnt_q <= b_cnt_q + count_t'(1);
                        err_q   <= wr_err_o;
                        if (wr_done_o) begin
                            state_q <= S_IDLE;
                        end else if (!empty_i) begin  // Next word already waiting
                            state_q <= S_ADDR;
                        end else begin
                            state_q <= S_WAIT;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: src/sync_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO with a type-parameterized payload.
 * FIFO_DEPTH must be a power of two; pushes while full are dropped.
 */
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t  = logic [31:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t        mem [FIFO_DEPTH];
    logic   [AW:0]   wr_ptr;  // MSB is the wrap bit
    logic   [AW:0]   rd_ptr;

    assign empty_o    = (wr_ptr == rd_ptr);
    assign full_o     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop_data_o = mem[rd_ptr[AW-1:0]];  // Head word is always visible

    always_ff @(posedge clk) begin
        if (push_i && !full_o) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i && !full_o) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: tb/axi_mem_model.sv
/*
 * Behavioral AXI3 slave memory for the padding DMA testbench.
 * Single-beat reads and writes, random ready/valid timing while bp_en_i is set,
 * and a SLVERR read response on err_addr_i while err_en_i is set.
 */
`timescale 1ns/100ps

module axi_mem_model #(
    parameter int MEM_WORDS = 4096
) (
    input  logic           clk,
    input  logic           bp_en_i,
    input  logic           err_en_i,
    input  axi_pkg::addr_t err_addr_i,
    input  axi_pkg::addr_t araddr_i,
    input  logic           arvalid_i,
    output logic           arready_o,
    output axi_pkg::data_t rdata_o,
    output axi_pkg::resp_t rresp_o,
    output logic           rlast_o,
    output logic           rvalid_o,
    input  logic           rready_i,
    input  axi_pkg::addr_t awaddr_i,
    input  logic           awvalid_i,
    output logic           awready_o,
    input  axi_pkg::data_t wdata_i,
    input  logic           wvalid_i,
    output logic           wready_o,
    output axi_pkg::resp_t bresp_o,
    output logic           bvalid_o,
    input  logic           bready_i
);

    import axi_pkg::*;

    localparam resp_t RESP_SLVERR = 2'b10;

    data_t mem [MEM_WORDS];
    addr_t rd_q [$];   // Accepted read addresses, oldest first
    addr_t wr_addr;
    addr_t rd_addr;
    addr_t fill_addr;
    logic  ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic  b_pend;     // Write data taken, response not yet offered

    function automatic int word_index(addr_t a);
        return int'(a[31:2]) % MEM_WORDS;
    endfunction

    // Ready or valid for this cycle, thinned out under back-pressure
    function automatic logic pass_random();
        return bp_en_i ? ($urandom_range(0, 3) != 0) : 1'b1;
    endfunction

    initial begin
        arready_o = 1'b0;
        rdata_o   = '0;
        rresp_o   = RESP_OKAY;
        rlast_o   = 1'b1;       // Every beat is the last one
        rvalid_o  = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bresp_o   = RESP_OKAY;
        bvalid_o  = 1'b0;
        b_pend    = 1'b0;
        wr_addr   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill_addr = addr_t'(i) << 2;
            mem[i]    = {fill_addr[15:0] ^ 16'h3C96, ~fill_addr[15:0]};
        end
        forever begin
            @(posedge clk);
            // Handshakes as the DUT sees them on this edge
            ar_hs = arvalid_i && arready_o;
            r_hs  = rvalid_o && rready_i;
            aw_hs = awvalid_i && awready_o;
            w_hs  = wvalid_i && wready_o;
            b_hs  = bvalid_o && bready_i;
            if (ar_hs) begin
                rd_q.push_back(araddr_i);
            end
            if (aw_hs) begin
                wr_addr = awaddr_i;
            end
            if (w_hs) begin
                mem[word_index(wr_addr)] = wdata_i;
                b_pend = 1'b1;
            end
            #1;
            if (r_hs) begin
                rvalid_o = 1'b0;
            end
            if (!rvalid_o && rd_q.size() > 0 && pass_random()) begin
                rd_addr  = rd_q.pop_front();
                rdata_o  = mem[word_index(rd_addr)];
                rresp_o  = (err_en_i && rd_addr == err_addr_i) ? RESP_SLVERR : RESP_OKAY;
                rvalid_o = 1'b1;
            end
            if (b_hs) begin
                bvalid_o = 1'b0;
            end
            if (b_pend && !bvalid_o && pass_random()) begin
                bvalid_o = 1'b1;
                b_pend   = 1'b0;
            end
            arready_o = pass_random();
            awready_o = pass_random();
            wready_o  = pass_random();
        end
    end

endmodule

// File: tb/mirror_pad_dma_assert.sv
/*
 * AXI handshake checks for the padding DMA, bound into mirror_pad_dma.
 */
`timescale 1ns/100ps

module mirror_pad_dma_assert (
    input logic           clk,
    input logic           rst_n,
    input logic           done_i,
    input axi_pkg::addr_t araddr_i,
    input logic           arvalid_i,
    input logic           arready_i,
    input logic           rready_i,
    input axi_pkg::addr_t awaddr_i,
    input logic           awvalid_i,
    input logic           awready_i,
    input logic           wvalid_i,
    input logic           wready_i
);

    logic aw_open_q;  // AW accepted, matching W not yet taken

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_open_q <= 1'b0;
        end else if (awvalid_i && awready_i) begin
            aw_open_q <= 1'b1;
        end else if (wvalid_i && wready_i) begin
            aw_open_q <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else $error("AR request dropped or changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else $error("AW request dropped or changed before awready");

    w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> aw_open_q)
        else $error("wvalid raised before the AW handshake of its write");

    quiet_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> !rready_i && !arvalid_i && !awvalid_i)
        else $error("bus activity while the engine reports done");

endmodule

bind mirror_pad_dma mirror_pad_dma_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_i    (done_o),
    .araddr_i  (araddr_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .rready_i  (rready_o),
    .awaddr_i  (awaddr_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i)
);

// File: tb/tb_mirror_pad_dma.sv
/*
 * Testbench for the mirror padding DMA. Runs padding jobs against the AXI
 * memory model and checks every destination word against a reference model.
 */
`timescale 1ns/100ps

module tb_mirror_pad_dma;

    import axi_pkg::*;
    import pad_pkg::*;

    localparam int    MEM_WORDS = 4096;
    localparam addr_t SRC_BASE  = 32'h0000_0100;
    // Sum of (W+2)^2 over all jobs, random widths taken at W=9
    localparam int    WATCHDOG_CYCLES = (36 + 16 + 3 * 121 + 2 * 49) * 40 + 1000;

    logic   clk;
    logic   rst_n;
    addr_t  src_addr, dst_addr, err_addr;
    width_t mat_width;
    logic   start, done, err, bp_en, err_en;
    addr_t  araddr, awaddr;
    logic [3:0] arlen, arid, awlen, awid, wstrb, wid;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic   arvalid, arready, rlast, rvalid, rready;
    logic   awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    data_t  rdata, wdata;
    resp_t  rresp, bresp;

    data_t  image [MEM_WORDS];  // Memory contents right after reset
    string  cur_name;
    addr_t  cur_src, cur_dst;
    int     cur_w;
    int     job_seq = 0;
    int     done_seq = 0;
    int     w_rand;

    mirror_pad_dma #(.FIFO_DEPTH(4)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(mat_width),
        .start_i(start), .done_o(done), .err_o(err),
        .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize), .arburst_o(arburst),
        .arid_o(arid), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast), .rvalid_i(rvalid),
        .rready_o(rready),
        .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize), .awburst_o(awburst),
        .awid_o(awid), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wid_o(wid),
        .wvalid_o(wvalid), .wready_i(wready),
        .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .bp_en_i(bp_en), .err_en_i(err_en), .err_addr_i(err_addr),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast), .rvalid_o(rvalid),
        .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int word_index(addr_t a);
        return int'(a[31:2]);
    endfunction

    // Edge-excluding reflection: 0 -> 1, W+1 -> W-2, others shift by one
    function automatic data_t expected_word(addr_t src, int w, int r, int c);
        int sr;
        int sc;
        sr = (r == 0) ? 1 : ((r == w + 1) ? w - 2 : r - 1);
        sc = (c == 0) ? 1 : ((c == w + 1) ? w - 2 : c - 1);
        return image[word_index(src) + sr * w + sc];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // AXI3 encodings of a single-beat INCR transfer of one full word with ID 0
    task automatic verify_fixed_fields(input string name);
        check_value({name, " arlen"}, 32'd0, 32'(arlen));
        check_value({name, " arsize"}, 32'd2, 32'(arsize));
        check_value({name, " arburst"}, 32'd1, 32'(arburst));
        check_value({name, " arid"}, 32'd0, 32'(arid));
        check_value({name, " awlen"}, 32'd0, 32'(awlen));
        check_value({name, " awsize"}, 32'd2, 32'(awsize));
        check_value({name, " awburst"}, 32'd1, 32'(awburst));
        check_value({name, " awid"}, 32'd0, 32'(awid));
        check_value({name, " wid"}, 32'd0, 32'(wid));
        check_value({name, " wstrb"}, 32'hF, 32'(wstrb));
        check_value({name, " wlast"}, 32'd1, 32'(wlast));
    endtask

    task automatic compare_job();
        int n;
        int base;
        int r;
        int c;
        n    = cur_w + 2;
        base = word_index(cur_dst);
        for (r = 0; r < n; r++) begin
            for (c = 0; c < n; c++) begin
                check_value($sformatf("%s r%0d c%0d", cur_name, r, c),
                            expected_word(cur_src, cur_w, r, c), u_mem.mem[base + r * n + c]);
            end
        end
        check_value({cur_name, " guard below"}, image[base - 1], u_mem.mem[base - 1]);
        check_value({cur_name, " guard above"}, image[base + n * n], u_mem.mem[base + n * n]);
    endtask

    // Compare process, woken once per finished job
    initial begin
        forever begin
            wait (job_seq != done_seq);
            compare_job();
            done_seq = job_seq;
        end
    end

    task automatic run_job(input string name, input addr_t dst, input int w,
                           input logic exp_err);
        @(posedge clk);
        #1;
        cur_name  = name;
        cur_src   = SRC_BASE;
        cur_dst   = dst;
        cur_w     = w;
        src_addr  = SRC_BASE;
        dst_addr  = dst;
        mat_width = width_t'(w);
        start     = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value({name, " busy"}, 32'd0, 32'(done));
        verify_fixed_fields(name);
        wait (done === 1'b1);
        #1;
        job_seq = job_seq + 1;
        wait (done_seq == job_seq);
        check_value({name, " err"}, 32'(exp_err), 32'(err));
    endtask

    initial begin
        void'($urandom(32'h850d));
        rst_n     = 1'b0;
        start     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        mat_width = '0;
        bp_en     = 1'b0;
        err_en    = 1'b0;
        err_addr  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = u_mem.mem[i];
        end
        @(posedge clk);
        #1;
        check_value("reset done", 32'd1, 32'(done));
        check_value("reset err", 32'd0, 32'(err));
        check_value("reset valids", 32'd0,
                    32'({arvalid, rready, awvalid, wvalid, bready}));
        verify_fixed_fields("reset");

        run_job("w4 no backpressure", 32'h0000_1000, 4, 1'b0);

        bp_en = 1'b1;
        run_job("w2 backpressure", 32'h0000_1400, 2, 1'b0);

        for (int k = 0; k < 3; k++) begin
            w_rand = int'($urandom_range(2, 9));
            run_job($sformatf("random run %0d w%0d", k, w_rand),
                    32'h0000_1800 + addr_t'(k) * 32'h400, w_rand, 1'b0);
        end

        // Source word (1,2) of a 5x5 matrix answers with SLVERR
        err_en   = 1'b1;
        err_addr = SRC_BASE + 32'd28;
        run_job("read error", 32'h0000_2400, 5, 1'b1);
        err_en = 1'b0;
        run_job("clean after error", 32'h0000_2800, 5, 1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the DMA did not finish all jobs within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
